/* Bender.yml */
package:
  name: wb_commit

sources:
  - files:
      - hw/la_wb_pkg.sv
      - hw/excp_encoder.sv
      - hw/mem_wb.sv
      - hw/trap_csr_file.sv
      - hw/gpr_file.sv
      - hw/wb_commit_top.sv
  - target: test
    files:
      - verif/wb_commit_checker.sv
      - verif/tb_wb_commit.sv

/* hw/excp_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module excp_encoder (
    input  wire la_wb_pkg::mem_to_wb_t  item_i,
    output la_wb_pkg::trap_info_t       info_o
);
    import la_wb_pkg::*;

    logic [3:0]  sel;
    logic        fetch_fault;
    logic        mem_fault;
    logic        tlb_fault;
    logic [31:0] fault_addr;

    // scan downwards so the lowest set bit is the last one kept
    always_comb begin
        sel = 4'd0;
        for (int i = 15; i >= 0; i--) begin
            if (item_i.excp_num[i]) begin
                sel = 4'(i);
            end
        end
    end

    assign fetch_fault = (sel >= EXC_ADEF) && (sel <= EXC_PPI_F);
    assign mem_fault   = (sel >= EXC_ALE);
    assign tlb_fault   = ((sel >= EXC_TLBR_F) && (sel <= EXC_PPI_F)) || (sel >= EXC_TLBR_M);
    assign fault_addr  = fetch_fault ? item_i.pc : item_i.wdata;

    always_comb begin
        info_o      = '0;
        info_o.take = item_i.valid && (item_i.excp_num != 16'd0);
        case (sel)
            EXC_INT:    info_o.ecode = INT;
            EXC_ADEF:   info_o.ecode = ADE;
            EXC_TLBR_F: info_o.ecode = TLBR;
            EXC_PIF:    info_o.ecode = PIF;
            EXC_PPI_F:  info_o.ecode = PPI;
            EXC_SYS:    info_o.ecode = SYS;
            EXC_BRK:    info_o.ecode = BRK;
            EXC_INE:    info_o.ecode = INE;
            EXC_IPE:    info_o.ecode = IPE;
            EXC_ALE:    info_o.ecode = ALE;
            EXC_ADEM:   info_o.ecode = ADE;
            EXC_TLBR_M: info_o.ecode = TLBR;
            EXC_PME:    info_o.ecode = PME;
            EXC_PPI_M:  info_o.ecode = PPI;
            EXC_PIS:    info_o.ecode = PIS;
            default:    info_o.ecode = PIL;
        endcase
        info_o.esubcode = (sel == EXC_ADEM) ? ESUB_ADEM : ESUB_ADEF;   // zero except for ADEM
        info_o.badv_we  = info_o.take && (fetch_fault || mem_fault);
        info_o.badv     = fault_addr;
        info_o.vppn_we  = info_o.take && tlb_fault;
        info_o.vppn     = fault_addr[31:13];
    end

endmodule

`default_nettype wire

/* hw/gpr_file.sv */
`timescale 1ns/10ps
`default_nettype none

module gpr_file (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire la_wb_pkg::wb_commit_t  wr_i,
    input  wire [4:0]                   raddr_i,
    output logic [31:0]                 rdata_o
);

    logic [31:0] regs [0:31];
    logic        wr_en;

    assign wr_en = wr_i.valid && wr_i.wreg && (wr_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en) begin
            regs[wr_i.rd] <= wr_i.wdata;
        end
    end

    // r0 is hardwired to zero
    assign rdata_o = (raddr_i == 5'd0) ? 32'd0 : regs[raddr_i];

endmodule

`default_nettype wire

/* hw/la_wb_pkg.sv */
`default_nettype none

package la_wb_pkg;

    typedef enum logic [2:0] {
        OP_NORMAL = 3'd0,
        OP_ERTN   = 3'd1,
        OP_LL     = 3'd2,
        OP_SC     = 3'd3
    } aluop_e;

    typedef enum logic [5:0] {
        INT  = 6'h00,
        PIL  = 6'h01,
        PIS  = 6'h02,
        PIF  = 6'h03,
        PME  = 6'h04,
        PPI  = 6'h07,
        ADE  = 6'h08,
        ALE  = 6'h09,
        SYS  = 6'h0B,
        BRK  = 6'h0C,
        INE  = 6'h0D,
        IPE  = 6'h0E,
        TLBR = 6'h3F
    } ecode_e;

    // bit positions in the 16-bit exception vector, lowest bit has priority
    localparam int EXC_INT    = 0;
    localparam int EXC_ADEF   = 1;
    localparam int EXC_TLBR_F = 2;
    localparam int EXC_PIF    = 3;
    localparam int EXC_PPI_F  = 4;
    localparam int EXC_SYS    = 5;
    localparam int EXC_BRK    = 6;
    localparam int EXC_INE    = 7;
    localparam int EXC_IPE    = 8;
    localparam int EXC_ALE    = 9;
    localparam int EXC_ADEM   = 10;
    localparam int EXC_TLBR_M = 11;
    localparam int EXC_PME    = 12;
    localparam int EXC_PPI_M  = 13;
    localparam int EXC_PIS    = 14;
    localparam int EXC_PIL    = 15;

    localparam logic [8:0] ESUB_ADEF = 9'd0;
    localparam logic [8:0] ESUB_ADEM = 9'd1;

    localparam logic [13:0] CSR_CRMD   = 14'h0;
    localparam logic [13:0] CSR_PRMD   = 14'h1;
    localparam logic [13:0] CSR_ESTAT  = 14'h5;
    localparam logic [13:0] CSR_ERA    = 14'h6;
    localparam logic [13:0] CSR_BADV   = 14'h7;
    localparam logic [13:0] CSR_TLBEHI = 14'h11;
    localparam logic [13:0] CSR_LLBCTL = 14'h60;

    typedef struct packed {
        logic        we;
        logic [13:0] addr;
        logic [31:0] data;
    } csr_write_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic        wreg;
        logic [31:0] wdata;   // faulting address for memory exceptions
        aluop_e      aluop;
        logic        llbit_we;
        logic        llbit_value;
        logic [15:0] excp_num;
        csr_write_t  csr_wr;
    } mem_to_wb_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic        wreg;
        logic [31:0] wdata;
    } wb_commit_t;

    typedef struct packed {
        logic        take;
        ecode_e      ecode;
        logic [8:0]  esubcode;
        logic        badv_we;
        logic [31:0] badv;
        logic        vppn_we;
        logic [18:0] vppn;
    } trap_info_t;

endpackage

`default_nettype wire

/* hw/mem_wb.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_wb (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         stall_i,
    input  wire                         flush_i,
    input  wire la_wb_pkg::mem_to_wb_t  mem_i,
    input  wire                         squash_i,
    output la_wb_pkg::wb_commit_t       wb_o,
    output la_wb_pkg::csr_write_t       csr_wr_o,
    output logic                        llbit_we_o,
    output logic                        llbit_value_o,
    output logic                        ertn_o
);
    import la_wb_pkg::*;

    logic clear;

    // a return only counts when nothing older or the trap logic kills it
    assign ertn_o = mem_i.valid && (mem_i.aluop == OP_ERTN) && !squash_i && !flush_i;
    assign clear  = flush_i || squash_i || ertn_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear) begin
            wb_o          <= '0;
            csr_wr_o      <= '0;
            llbit_we_o    <= 1'b0;
            llbit_value_o <= 1'b0;
        end else if (stall_i) begin
            wb_o.valid <= 1'b0;   // data held, commit pulses only once
        end else begin
            wb_o.valid <= mem_i.valid;
            if (mem_i.valid) begin
                wb_o.pc       <= mem_i.pc;
                wb_o.instr    <= mem_i.instr;
                wb_o.rd       <= mem_i.rd;
                wb_o.wreg     <= mem_i.wreg;
                wb_o.wdata    <= mem_i.wdata;
                csr_wr_o      <= mem_i.csr_wr;
                llbit_we_o    <= mem_i.llbit_we;
                llbit_value_o <= mem_i.llbit_value;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/trap_csr_file.sv */
`timescale 1ns/10ps
`default_nettype none

module trap_csr_file (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire la_wb_pkg::trap_info_t  info_i,
    input  wire [31:0]                  epc_i,
    input  wire                         ertn_i,
    input  wire la_wb_pkg::wb_commit_t  commit_i,
    input  wire la_wb_pkg::csr_write_t  csr_wr_i,
    input  wire                         llbit_we_i,
    input  wire                         llbit_value_i,
    input  wire [13:0]                  raddr_i,
    output logic [31:0]                 rdata_o,
    output logic [31:0]                 era_o,
    output logic                        excp_flush_o,
    output logic                        ertn_flush_o
);
    import la_wb_pkg::*;

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    ecode_e      estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era;
    logic [31:0] badv;
    logic [18:0] tlbehi_vppn;
    logic        llbit;
    logic        csr_we;

    assign csr_we = commit_i.valid && csr_wr_i.we;
    assign era_o  = era;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd_plv       <= 2'd0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= 2'd0;
            prmd_pie       <= 1'b0;
            estat_ecode    <= INT;
            estat_esubcode <= 9'd0;
            era            <= 32'd0;
            badv           <= 32'd0;
            tlbehi_vppn    <= 19'd0;
            llbit          <= 1'b0;
        end else if (info_i.take) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            crmd_plv       <= 2'd0;   // handler runs in kernel mode with interrupts off
            crmd_ie        <= 1'b0;
            estat_ecode    <= info_i.ecode;
            estat_esubcode <= info_i.esubcode;
            era            <= epc_i;
            if (info_i.badv_we) begin
                badv <= info_i.badv;
            end
            if (info_i.vppn_we) begin
                tlbehi_vppn <= info_i.vppn;
            end
        end else if (ertn_i) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
            llbit    <= 1'b0;
        end else begin
            if (commit_i.valid && llbit_we_i) begin
                llbit <= llbit_value_i;
            end
            if (csr_we) begin
                case (csr_wr_i.addr)
                    CSR_CRMD: begin
                        crmd_plv <= csr_wr_i.data[1:0];
                        crmd_ie  <= csr_wr_i.data[2];
                    end
                    CSR_PRMD: begin
                        prmd_pplv <= csr_wr_i.data[1:0];
                        prmd_pie  <= csr_wr_i.data[2];
                    end
                    CSR_ERA:    era         <= csr_wr_i.data;
                    CSR_BADV:   badv        <= csr_wr_i.data;
                    CSR_TLBEHI: tlbehi_vppn <= csr_wr_i.data[31:13];
                    CSR_LLBCTL: if (csr_wr_i.data[1]) llbit <= 1'b0;   // wcllb clears the LLbit
                    default: ;   // ESTAT cause fields are read only
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            excp_flush_o <= 1'b0;
            ertn_flush_o <= 1'b0;
        end else begin
            excp_flush_o <= info_i.take;
            ertn_flush_o <= ertn_i;
        end
    end

    always_comb begin
        case (raddr_i)
            CSR_CRMD:   rdata_o = {29'd0, crmd_ie, crmd_plv};
            CSR_PRMD:   rdata_o = {29'd0, prmd_pie, prmd_pplv};
            CSR_ESTAT:  rdata_o = {1'b0, estat_esubcode, estat_ecode, 16'd0};
            CSR_ERA:    rdata_o = era;
            CSR_BADV:   rdata_o = badv;
            CSR_TLBEHI: rdata_o = {tlbehi_vppn, 13'd0};
            CSR_LLBCTL: rdata_o = {31'd0, llbit};
            default:    rdata_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/wb_commit_top.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_commit_top (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire la_wb_pkg::mem_to_wb_t  mem_i,
    input  wire                         stall_i,
    input  wire                         flush_i,
    input  wire [4:0]                   rs_addr_i,
    output logic [31:0]                 rs_data_o,
    input  wire [13:0]                  csr_raddr_i,
    output logic [31:0]                 csr_rdata_o,
    output la_wb_pkg::wb_commit_t       commit_o,
    output logic                        excp_flush_o,
    output logic                        ertn_flush_o,
    output logic [31:0]                 era_o
);
    import la_wb_pkg::*;

    mem_to_wb_t enc_item;
    trap_info_t trap_info;
    csr_write_t csr_wr;
    logic       llbit_we;
    logic       llbit_value;
    logic       ertn;

    // a flushed item raises no trap
    always_comb begin
        enc_item       = mem_i;
        enc_item.valid = mem_i.valid && !flush_i;
    end

    excp_encoder i_excp_encoder (
        .item_i (enc_item),
        .info_o (trap_info)
    );

    mem_wb i_mem_wb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .mem_i         (mem_i),
        .squash_i      (trap_info.take),
        .wb_o          (commit_o),
        .csr_wr_o      (csr_wr),
        .llbit_we_o    (llbit_we),
        .llbit_value_o (llbit_value),
        .ertn_o        (ertn)
    );

    trap_csr_file i_trap_csr_file (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .info_i        (trap_info),
        .epc_i         (mem_i.pc),
        .ertn_i        (ertn),
        .commit_i      (commit_o),
        .csr_wr_i      (csr_wr),
        .llbit_we_i    (llbit_we),
        .llbit_value_i (llbit_value),
        .raddr_i       (csr_raddr_i),
        .rdata_o       (csr_rdata_o),
        .era_o         (era_o),
        .excp_flush_o  (excp_flush_o),
        .ertn_flush_o  (ertn_flush_o)
    );

    gpr_file i_gpr_file (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (commit_o),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

endmodule

`default_nettype wire

/* src.f */
hw/la_wb_pkg.sv
hw/excp_encoder.sv
hw/mem_wb.sv
hw/trap_csr_file.sv
hw/gpr_file.sv
hw/wb_commit_top.sv
verif/wb_commit_checker.sv
verif/tb_wb_commit.sv

/* verif/tb_wb_commit.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_wb_commit;
    import la_wb_pkg::*;

    // cause code per exception bit, bit 15 in the top slot
    localparam logic [95:0] ECODE_BITS = {6'h01, 6'h02, 6'h07, 6'h04, 6'h3F, 6'h08, 6'h09, 6'h0E,
                                          6'h0D, 6'h0C, 6'h0B, 6'h07, 6'h03, 6'h3F, 6'h08, 6'h00};
    localparam logic [15:0] FETCH_MASK = 16'h001E;
    localparam logic [15:0] MEM_MASK   = 16'hFE00;
    localparam logic [15:0] TLB_MASK   = 16'hF81C;

    logic        clk;
    logic        rst_n;
    mem_to_wb_t  mem_d;
    logic        stall_d;
    logic        flush_d;
    logic [4:0]  rs_addr;
    logic [31:0] rs_data;
    logic [13:0] csr_raddr;
    logic [31:0] csr_rdata;
    wb_commit_t  commit;
    logic        excp_flush;
    logic        ertn_flush;
    logic [31:0] era;
    int          checks;
    int          errors;
    logic [4:0]  rd_prev;
    logic [4:0]  rd_prev2;

    // expected state of the writeback stage, the CSRs and the register file
    wb_commit_t  m_wb;
    csr_write_t  m_csr;
    logic        m_llwe;
    logic        m_llval;
    logic        m_excp_fl;
    logic        m_ertn_fl;
    logic [2:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic [5:0]  m_ecode;
    logic [8:0]  m_esub;
    logic [31:0] m_era;
    logic [31:0] m_badv;
    logic [18:0] m_vppn;
    logic        m_llbit;
    logic [31:0] m_gpr [32];

    wb_commit_top i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .mem_i        (mem_d),
        .stall_i      (stall_d),
        .flush_i      (flush_d),
        .rs_addr_i    (rs_addr),
        .rs_data_o    (rs_data),
        .csr_raddr_i  (csr_raddr),
        .csr_rdata_o  (csr_rdata),
        .commit_o     (commit),
        .excp_flush_o (excp_flush),
        .ertn_flush_o (ertn_flush),
        .era_o        (era)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void ref_step(input mem_to_wb_t it, input logic st, input logic fl,
                                     input logic rn);
        logic        take;
        logic        ertn;
        int          bit_no;
        logic [31:0] addr;
        if (!rn) begin
            m_wb      = '0;
            m_csr     = '0;
            m_llwe    = 1'b0;
            m_llval   = 1'b0;
            m_excp_fl = 1'b0;
            m_ertn_fl = 1'b0;
            m_crmd    = 3'd0;
            m_prmd    = 3'd0;
            m_ecode   = 6'd0;
            m_esub    = 9'd0;
            m_era     = 32'd0;
            m_badv    = 32'd0;
            m_vppn    = 19'd0;
            m_llbit   = 1'b0;
            for (int i = 0; i < 32; i++) begin
                m_gpr[i] = 32'd0;
            end
            return;
        end
        take = it.valid && !fl && (it.excp_num != 16'd0);
        ertn = it.valid && !fl && !take && (it.aluop == OP_ERTN);
        if (m_wb.valid && m_wb.wreg && (m_wb.rd != 5'd0)) begin
            m_gpr[m_wb.rd] = m_wb.wdata;   // the item in writeback retires at this edge
        end
        if (take) begin
            bit_no = 0;
            while (bit_no < 15 && !it.excp_num[bit_no]) begin
                bit_no++;
            end
            addr    = FETCH_MASK[bit_no] ? it.pc : it.wdata;
            m_prmd  = m_crmd;
            m_crmd  = 3'd0;
            m_ecode = ECODE_BITS[bit_no*6 +: 6];
            m_esub  = (bit_no == EXC_ADEM) ? ESUB_ADEM : 9'd0;
            m_era   = it.pc;
            if (FETCH_MASK[bit_no] || MEM_MASK[bit_no]) begin
                m_badv = addr;
            end
            if (TLB_MASK[bit_no]) begin
                m_vppn = addr[31:13];
            end
        end else if (ertn) begin
            m_crmd  = m_prmd;
            m_llbit = 1'b0;
        end else if (m_wb.valid) begin
            if (m_llwe) begin
                m_llbit = m_llval;
            end
            if (m_csr.we) begin
                case (m_csr.addr)
                    CSR_CRMD:   m_crmd = m_csr.data[2:0];
                    CSR_PRMD:   m_prmd = m_csr.data[2:0];
                    CSR_ERA:    m_era  = m_csr.data;
                    CSR_BADV:   m_badv = m_csr.data;
                    CSR_TLBEHI: m_vppn = m_csr.data[31:13];
                    CSR_LLBCTL: m_llbit = m_csr.data[1] ? 1'b0 : m_llbit;
                    default: ;
                endcase
            end
        end
        m_excp_fl = take;
        m_ertn_fl = ertn;
        if (fl || take || ertn) begin
            m_wb    = '0;
            m_csr   = '0;
            m_llwe  = 1'b0;
            m_llval = 1'b0;
        end else if (st) begin
            m_wb.valid = 1'b0;
        end else begin
            m_wb.valid = it.valid;
            if (it.valid) begin
                m_wb.pc    = it.pc;
                m_wb.instr = it.instr;
                m_wb.rd    = it.rd;
                m_wb.wreg  = it.wreg;
                m_wb.wdata = it.wdata;
                m_csr      = it.csr_wr;
                m_llwe     = it.llbit_we;
                m_llval    = it.llbit_value;
            end
        end
    endfunction

    function automatic logic [31:0] csr_value(input logic [13:0] a);
        case (a)
            CSR_CRMD:   return {29'd0, m_crmd};
            CSR_PRMD:   return {29'd0, m_prmd};
            CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 16'd0};
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_TLBEHI: return {m_vppn, 13'd0};
            CSR_LLBCTL: return {31'd0, m_llbit};
            default:    return 32'd0;
        endcase
    endfunction

    function automatic logic [13:0] pick_csr();
        case ($urandom_range(0, 7))
            0:       return CSR_CRMD;
            1:       return CSR_PRMD;
            2:       return CSR_ESTAT;
            3:       return CSR_ERA;
            4:       return CSR_BADV;
            5:       return CSR_TLBEHI;
            6:       return CSR_LLBCTL;
            default: return 14'h2a;   // not implemented, reads as zero
        endcase
    endfunction

    function automatic mem_to_wb_t random_item();
        mem_to_wb_t it;
        it       = '0;
        it.valid = 1'b1;
        it.pc    = $urandom & 32'hffff_fffc;
        it.instr = $urandom;
        it.rd    = 5'($urandom);
        it.wreg  = 1'($urandom_range(0, 1));
        it.wdata = $urandom;
        it.aluop = OP_NORMAL;
        return it;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic drive(input mem_to_wb_t it, input logic st, input logic fl);
        @(posedge clk);
        mem_d     <= it;
        stall_d   <= st;
        flush_d   <= fl;
        rs_addr   <= ($urandom_range(0, 1) == 1) ? rd_prev2 : 5'($urandom);
        csr_raddr <= pick_csr();
        rd_prev2 = rd_prev;   // its write has landed by the time this read is sampled
        rd_prev  = it.rd;
    endtask

    task automatic await_pulse(input string what);
        logic seen;
        int   waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < 8) begin
            @(negedge clk);
            if (what == "commit") begin
                seen = commit.valid;
            end else if (what == "exception") begin
                seen = excp_flush;
            end else begin
                seen = ertn_flush;
            end
            waited++;
        end
        assert (seen) else begin
            errors++;
            $display("no %s pulse seen within 8 cycles", what);
        end
    endtask

    always @(posedge clk) ref_step(mem_d, stall_d, flush_d, rst_n);

    always @(negedge clk) begin
        if (rst_n) begin
            check_value("commit_o", commit, m_wb);
            check_value("excp_flush_o", excp_flush, m_excp_fl);
            check_value("ertn_flush_o", ertn_flush, m_ertn_fl);
            check_value("era_o", era, m_era);
            check_value("rs_data_o", rs_data, m_gpr[rs_addr]);
            check_value("csr_rdata_o", csr_rdata, csr_value(csr_raddr));
        end
    end

    initial begin
        #100us;
        $display("run stopped by the watchdog after 100 us");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        mem_to_wb_t it;
        int         b;
        int         fails;
        void'($urandom(32'hfdb19c95));
        rst_n     = 1'b0;
        mem_d     = '0;
        stall_d   = 1'b0;
        flush_d   = 1'b0;
        rs_addr   = 5'd0;
        csr_raddr = 14'd0;
        checks    = 0;
        errors    = 0;
        rd_prev   = 5'd0;
        rd_prev2  = 5'd0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        repeat (40) begin
            it       = random_item();
            it.valid = ($urandom_range(0, 4) != 0);   // an occasional bubble
            drive(it, 1'b0, 1'b0);
        end

        repeat (4) begin
            it = random_item();
            repeat ($urandom_range(2, 5)) drive(it, 1'b1, 1'b0);
            drive(it, 1'b0, 1'b0);
            drive('0, 1'b0, 1'b0);
            await_pulse("commit");
        end

        repeat (32) begin
            it        = random_item();
            it.csr_wr = '{we: 1'b1, addr: CSR_CRMD, data: $urandom};
            drive(it, 1'b0, 1'b0);
            drive('0, 1'b0, 1'b0);
            b           = $urandom_range(0, 15);
            it          = random_item();
            it.excp_num = (16'($urandom) | 16'd1) << b;   // bit b is the lowest one set
            drive(it, 1'($urandom_range(0, 1)), 1'b0);
            drive('0, 1'b0, 1'b0);
            await_pulse("exception");
        end

        repeat (8) begin
            it          = random_item();
            it.excp_num = 16'd1 << $urandom_range(0, 15);
            drive(it, 1'b0, 1'b0);
            drive('0, 1'b0, 1'b0);
            await_pulse("exception");
            it             = random_item();
            it.aluop       = OP_LL;
            it.llbit_we    = 1'b1;
            it.llbit_value = 1'b1;
            it.csr_wr      = '{we: 1'b1, addr: CSR_PRMD, data: $urandom};
            drive(it, 1'b0, 1'b0);
            drive('0, 1'b0, 1'b0);
            it       = random_item();
            it.aluop = OP_ERTN;
            drive(it, 1'b0, 1'b0);
            drive('0, 1'b0, 1'b0);
            await_pulse("return");
        end

        repeat (40) begin
            it             = random_item();
            it.csr_wr      = '{we: 1'b1, addr: pick_csr(), data: $urandom};
            it.llbit_we    = 1'($urandom_range(0, 1));
            it.llbit_value = 1'($urandom_range(0, 1));
            drive(it, 1'b0, ($urandom_range(0, 3) == 0));
        end
        repeat (3) drive('0, 1'b0, 1'b0);

        fails = i_dut.i_checker.fail_count;
        $display("checks %0d, compare errors %0d, assertion failures %0d", checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/wb_commit_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_commit_checker (
    input wire                         clk,
    input wire                         rst_n_i,
    input wire la_wb_pkg::wb_commit_t  commit_i,
    input wire                         excp_flush_i,
    input wire                         ertn_flush_i
);

    int fail_count;   // read by the testbench at the end of the run

    flush_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(excp_flush_i && ertn_flush_i))
        else begin
            $error("exception and return flush are high in the same cycle");
            fail_count++;
        end

    excp_flush_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        excp_flush_i |=> !excp_flush_i)
        else begin
            $error("exception flush lasted more than one cycle");
            fail_count++;
        end

    ertn_flush_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        ertn_flush_i |=> !ertn_flush_i)
        else begin
            $error("return flush lasted more than one cycle");
            fail_count++;
        end

    no_commit_on_trap: assert property (@(posedge clk) disable iff (!rst_n_i)
        excp_flush_i |-> !commit_i.valid)
        else begin
            $error("commit valid while the exception flush is high");
            fail_count++;
        end

    // the first cycle out of reset is quiet on all three outputs
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> (!excp_flush_i && !ertn_flush_i && !commit_i.valid))
        else begin
            $error("commit or flush active in the first cycle after reset");
            fail_count++;
        end

endmodule

bind wb_commit_top wb_commit_checker i_checker (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .commit_i     (commit_o),
    .excp_flush_i (excp_flush_o),
    .ertn_flush_i (ertn_flush_o)
);

`default_nettype wire
